// File: logic/pin_ctrl_pkg.sv
// pin-side types shared by pin controllers, sample arbiter and sample buffer
// sample stamps hold only the low 11 bits of the time counter and wrap freely
// the pin field is 4 bits wide, so at most 16 pins can be told apart
`default_nettype none

package pin_ctrl_pkg;

  // output waveform kinds; sawtooth and triangle are not supported
  typedef enum logic [1:0] {
    WAVE_CONST  = 2'd0,
    WAVE_SQUARE = 2'd1,
    WAVE_PWM    = 2'd2
  } wave_e;

  // active waveform setting of one pin
  typedef struct packed {
    wave_e       wave;
    // square: half period, pwm: full period
    logic [15:0] param_a;
    // pwm: high ticks, constant: level in bit 0
    logic [15:0] param_b;
  } pin_cfg_t;

  // one entry of the sample memory
  typedef struct packed {
    logic [3:0]  pin;
    logic        value;
    logic [10:0] stamp;
  } sample_t;

endpackage

`default_nettype wire

// File: logic/host_bus_pkg.sv
// register map, command record and opcodes of the host port
// all addresses are 16-bit word addresses on a 5-bit host address bus
// status bits above sample_dropped always read as zero
`default_nettype none

package host_bus_pkg;

  typedef enum logic [1:0] {
    OP_SET_WAVE     = 2'd0,
    OP_START_SAMPLE = 2'd1,
    OP_STOP_SAMPLE  = 2'd2,
    OP_RESET_TIME   = 2'd3
  } cmd_op_e;

  // one timed command, 72 bits
  typedef struct packed {
    logic [31:0]         exec_time;
    logic [3:0]          pin;
    cmd_op_e             op;
    pin_ctrl_pkg::wave_e wave;
    logic [15:0]         param_a;
    logic [15:0]         param_b;
  } cmd_t;

  // write side: staging registers and commit
  localparam logic [4:0] REG_TIME_HI      = 5'd0;
  localparam logic [4:0] REG_TIME_LO      = 5'd1;
  // pin in 3:0, opcode in 5:4, waveform in 7:6
  localparam logic [4:0] REG_PIN_OP       = 5'd2;
  localparam logic [4:0] REG_PARAM_A      = 5'd3;
  localparam logic [4:0] REG_PARAM_B      = 5'd4;
  localparam logic [4:0] REG_COMMIT       = 5'd5;

  // read side
  localparam logic [4:0] REG_STATUS       = 5'd8;
  localparam logic [4:0] REG_SAMPLE       = 5'd9;
  localparam logic [4:0] REG_SAMPLE_COUNT = 5'd10;
  localparam logic [4:0] REG_TIME_NOW     = 5'd11;

  // status word, fifo_empty in bit 0
  typedef struct packed {
    logic [11:0] reserved;
    logic        sample_dropped;
    logic        cmd_dropped;
    logic        fifo_full;
    logic        fifo_empty;
  } status_t;

endpackage

`default_nettype wire

// File: logic/host_port.sv
// host register port: staged command writes, registered reads
// no back-pressure, so a commit into a full FIFO is lost and flagged
// REG_TIME_NOW returns only the low 16 bits of the time counter
// a REG_SAMPLE read on an empty buffer returns zero and pops nothing
`timescale 1ns/1ps
`default_nettype none

module host_port (
  input  logic                   sys_clk,
  input  logic                   global_clock_reset,
  input  logic [4:0]             host_addr,
  input  logic [15:0]            host_wdata,
  input  logic                   host_wr,
  input  logic                   host_rd,
  output logic [15:0]            host_rdata,
  output logic                   host_rvalid,
  output logic                   push,
  output host_bus_pkg::cmd_t     cmd,
  input  logic                   fifo_full,
  input  logic                   fifo_empty,
  input  logic [31:0]            time_now,
  output logic                   rd_pop,
  input  pin_ctrl_pkg::sample_t  rd_data,
  input  logic [15:0]            count,
  input  logic                   sample_dropped
);

  logic                  cmd_dropped;
  host_bus_pkg::status_t status_word;

  // commit goes straight to the FIFO write port
  assign push   = host_wr && (host_addr == host_bus_pkg::REG_COMMIT);
  // only pop when there is something to pop
  assign rd_pop = host_rd && (host_addr == host_bus_pkg::REG_SAMPLE) && (count != 16'd0);

  always_comb begin
    status_word                = '0;
    status_word.fifo_empty     = fifo_empty;
    status_word.fifo_full      = fifo_full;
    status_word.cmd_dropped    = cmd_dropped;
    status_word.sample_dropped = sample_dropped;
  end

  // staging registers and the sticky drop flag
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      cmd         <= '0;
      cmd_dropped <= 1'b0;
    end else if (host_wr) begin
      case (host_addr)
        host_bus_pkg::REG_TIME_HI: cmd.exec_time[31:16] <= host_wdata;
        host_bus_pkg::REG_TIME_LO: cmd.exec_time[15:0]  <= host_wdata;
        host_bus_pkg::REG_PIN_OP: begin
          cmd.pin  <= host_wdata[3:0];
          cmd.op   <= host_bus_pkg::cmd_op_e'(host_wdata[5:4]);
          cmd.wave <= pin_ctrl_pkg::wave_e'(host_wdata[7:6]);
        end
        host_bus_pkg::REG_PARAM_A: cmd.param_a <= host_wdata;
        host_bus_pkg::REG_PARAM_B: cmd.param_b <= host_wdata;
        // staged fields are kept, so a commit can be repeated
        host_bus_pkg::REG_COMMIT:  cmd_dropped <= cmd_dropped | fifo_full;
        default: ;
      endcase
    end
  end

  // read strobe echo
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      host_rvalid <= 1'b0;
    end else begin
      host_rvalid <= host_rd;
    end
  end

  // read data mux, sampled on the read strobe
  always_ff @(posedge sys_clk) begin
    if (host_rd) begin
      case (host_addr)
        host_bus_pkg::REG_STATUS:       host_rdata <= status_word;
        host_bus_pkg::REG_SAMPLE:       host_rdata <= rd_pop ? rd_data : 16'd0;
        host_bus_pkg::REG_SAMPLE_COUNT: host_rdata <= count;
        host_bus_pkg::REG_TIME_NOW:     host_rdata <= time_now[15:0];
        default:                        host_rdata <= 16'd0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/command_fifo.sv
// synchronous first-word-fall-through FIFO of command records
// head is valid whenever empty is low; a push while full is ignored
// FIFO_DEPTH need not be a power of two
`timescale 1ns/1ps
`default_nettype none

module command_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic               sys_clk,
  input  logic               global_clock_reset,
  input  logic               push,
  input  host_bus_pkg::cmd_t din,
  input  logic               pop,
  output host_bus_pkg::cmd_t head,
  output logic               empty,
  output logic               full
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  host_bus_pkg::cmd_t mem [FIFO_DEPTH];
  logic [AW-1:0]      wr_ptr;
  logic [AW-1:0]      rd_ptr;
  logic [CW-1:0]      occ;
  logic               wr_ok;
  logic               rd_ok;

  assign empty = (occ == '0);
  assign full  = (occ == CW'(FIFO_DEPTH));
  assign wr_ok = push && !full;
  assign rd_ok = pop && !empty;
  // fall-through head
  assign head  = mem[rd_ptr];

  // storage, no reset
  always_ff @(posedge sys_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leave occupancy alone
      if (wr_ok && !rd_ok) begin
        occ <= occ + 1'b1;
      end else if (rd_ok && !wr_ok) begin
        occ <= occ - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/event_scheduler.sv
// free-running 32-bit time counter and timed release of the FIFO head
// release is combinational: cmd_bus_valid and pop rise in the same cycle
// one HOLD cycle follows every release, so at most one command per two cycles
// OP_RESET_TIME zeroes the counter at the edge that ends the release cycle
`timescale 1ns/1ps
`default_nettype none

module event_scheduler (
  input  logic               sys_clk,
  input  logic               global_clock_reset,
  input  host_bus_pkg::cmd_t head,
  input  logic               empty,
  output logic               pop,
  output logic               cmd_bus_valid,
  output host_bus_pkg::cmd_t cmd_bus,
  output logic [31:0]        time_now
);

  typedef enum logic {
    IDLE,
    HOLD
  } sched_state_e;

  sched_state_e state;
  logic         release_now;

  // head is due once time has caught up with it
  assign release_now   = (state == IDLE) && !empty && (time_now >= head.exec_time);
  assign pop           = release_now;
  assign cmd_bus_valid = release_now;
  // bus carries the head; only meaningful while cmd_bus_valid is high
  assign cmd_bus       = head;

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (release_now) begin
            state <= HOLD;
          end
        end
        // lets the popped FIFO present its next head
        default: state <= IDLE;
      endcase
    end
  end

  // time base
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      time_now <= '0;
    end else if (release_now && (head.op == host_bus_pkg::OP_RESET_TIME)) begin
      time_now <= '0;
    end else begin
      time_now <= time_now + 32'd1;
    end
  end

endmodule

`default_nettype wire

// File: logic/pin_controller.sv
// one pin: constant, square or PWM output plus a periodic input sampler
// param_a must be at least 1 for square, PWM and sampling
// a capture that finds the previous request still ungranted is skipped
`timescale 1ns/1ps
`default_nettype none

module pin_controller #(
  parameter int PIN_INDEX = 0
) (
  input  logic                  sys_clk,
  input  logic                  global_clock_reset,
  input  logic                  cmd_bus_valid,
  input  host_bus_pkg::cmd_t    cmd_bus,
  input  logic [31:0]           time_now,
  input  logic                  pin_in,
  output logic                  pin_out,
  output logic                  sample_req,
  output pin_ctrl_pkg::sample_t sample_word,
  input  logic                  sample_grant
);

  localparam logic [3:0] MY_PIN = 4'(PIN_INDEX);

  pin_ctrl_pkg::pin_cfg_t cfg;
  logic [15:0]            tick;
  logic                   sq_level;
  logic                   sample_on;
  logic [15:0]            sample_period;
  logic [15:0]            sample_cnt;
  logic                   hit;
  logic                   tick_last;
  logic                   capture;
  logic                   take;

  assign hit       = cmd_bus_valid && (cmd_bus.pin == MY_PIN);
  assign tick_last = (tick == cfg.param_a - 16'd1);
  assign capture   = sample_on && (sample_cnt == sample_period - 16'd1);
  // a grant in the same cycle frees the slot for the new capture
  assign take      = capture && (!sample_req || sample_grant);

  // waveform state
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      cfg      <= '{wave: pin_ctrl_pkg::WAVE_CONST, param_a: 16'd0, param_b: 16'd0};
      tick     <= '0;
      sq_level <= 1'b0;
    end else if (hit && (cmd_bus.op == host_bus_pkg::OP_SET_WAVE)) begin
      cfg      <= '{wave: cmd_bus.wave, param_a: cmd_bus.param_a, param_b: cmd_bus.param_b};
      tick     <= '0;
      // square always starts with its high half
      sq_level <= 1'b1;
    end else begin
      // one counter wraps at param_a for both square and pwm
      tick <= tick_last ? '0 : tick + 16'd1;
      if (tick_last && (cfg.wave == pin_ctrl_pkg::WAVE_SQUARE)) begin
        sq_level <= ~sq_level;
      end
    end
  end

  always_comb begin
    case (cfg.wave)
      pin_ctrl_pkg::WAVE_SQUARE: pin_out = sq_level;
      pin_ctrl_pkg::WAVE_PWM:    pin_out = (tick < cfg.param_b);
      default:                   pin_out = cfg.param_b[0];
    endcase
  end

  // sampler control and request handshake
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      sample_on     <= 1'b0;
      sample_period <= '0;
      sample_cnt    <= '0;
      sample_req    <= 1'b0;
    end else begin
      if (hit && (cmd_bus.op == host_bus_pkg::OP_START_SAMPLE)) begin
        sample_on     <= 1'b1;
        sample_period <= cmd_bus.param_a;
        sample_cnt    <= '0;
      end else if (hit && (cmd_bus.op == host_bus_pkg::OP_STOP_SAMPLE)) begin
        sample_on <= 1'b0;
      end else if (sample_on) begin
        sample_cnt <= capture ? '0 : sample_cnt + 16'd1;
      end
      // request held until granted
      if (sample_grant) begin
        sample_req <= 1'b0;
      end
      if (take) begin
        sample_req <= 1'b1;
      end
    end
  end

  // captured word
  always_ff @(posedge sys_clk) begin
    if (take) begin
      sample_word <= '{pin: MY_PIN, value: pin_in, stamp: time_now[10:0]};
    end
  end

endmodule

`default_nettype wire

// File: logic/sample_arbiter.sv
// round-robin grant of pin sample requests to the sample memory write port
// one grant per cycle; the search starts after the last pin granted
// wr_en and wr_data are combinational, written in the grant cycle
`timescale 1ns/1ps
`default_nettype none

module sample_arbiter #(
  parameter int NUM_PINS = 8
) (
  input  logic                                 sys_clk,
  input  logic                                 global_clock_reset,
  input  logic [NUM_PINS-1:0]                  sample_req,
  input  pin_ctrl_pkg::sample_t [NUM_PINS-1:0] sample_word,
  output logic [NUM_PINS-1:0]                  sample_grant,
  output logic                                 wr_en,
  output pin_ctrl_pkg::sample_t                wr_data
);

  localparam int PW = (NUM_PINS > 1) ? $clog2(NUM_PINS) : 1;

  logic [PW-1:0] last;
  logic [PW-1:0] sel;
  logic          found;

  // scan all pins, starting one past the last winner
  always_comb begin
    int idx;
    found = 1'b0;
    sel   = last;
    for (int k = 1; k <= NUM_PINS; k++) begin
      idx = (int'(last) + k) % NUM_PINS;
      if (!found && sample_req[idx]) begin
        found = 1'b1;
        sel   = PW'(idx);
      end
    end
  end

  assign sample_grant = found ? (NUM_PINS'(1) << sel) : '0;
  assign wr_en        = found;
  assign wr_data      = sample_word[sel];

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      // pin 0 wins the first contest
      last <= PW'(NUM_PINS - 1);
    end else if (found) begin
      last <= sel;
    end
  end

endmodule

`default_nettype wire

// File: logic/sample_buffer.sv
// circular sample memory, oldest word always shown on rd_data
// a write into a full buffer is lost and sets the sticky sample_dropped
// count is zero-extended to 16 bits for the host read word
`timescale 1ns/1ps
`default_nettype none

module sample_buffer #(
  parameter int SAMPLE_DEPTH = 64
) (
  input  logic                  sys_clk,
  input  logic                  global_clock_reset,
  input  logic                  wr_en,
  input  pin_ctrl_pkg::sample_t wr_data,
  input  logic                  rd_pop,
  output pin_ctrl_pkg::sample_t rd_data,
  output logic [15:0]           count,
  output logic                  sample_dropped
);

  localparam int AW = (SAMPLE_DEPTH > 1) ? $clog2(SAMPLE_DEPTH) : 1;
  localparam int CW = $clog2(SAMPLE_DEPTH + 1);

  pin_ctrl_pkg::sample_t mem [SAMPLE_DEPTH];
  logic [AW-1:0]         wr_ptr;
  logic [AW-1:0]         rd_ptr;
  logic [CW-1:0]         occ;
  logic                  full;
  logic                  wr_ok;
  logic                  rd_ok;

  assign full    = (occ == CW'(SAMPLE_DEPTH));
  assign wr_ok   = wr_en && !full;
  assign rd_ok   = rd_pop && (occ != '0);
  assign rd_data = mem[rd_ptr];
  assign count   = 16'(occ);

  always_ff @(posedge sys_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      occ            <= '0;
      sample_dropped <= 1'b0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= (wr_ptr == AW'(SAMPLE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == AW'(SAMPLE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (wr_ok && !rd_ok) begin
        occ <= occ + 1'b1;
      end else if (rd_ok && !wr_ok) begin
        occ <= occ - 1'b1;
      end
      // sticky until reset
      if (wr_en && full) begin
        sample_dropped <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/mecobo_core.sv
// stimulus and sampling core: host port, command FIFO, scheduler,
// a row of pin controllers, sample arbiter and sample buffer
// single clock domain; NUM_PINS at most 16 because of the 4-bit pin field
`timescale 1ns/1ps
`default_nettype none

module mecobo_core #(
  parameter int NUM_PINS     = 8,
  parameter int FIFO_DEPTH   = 16,
  parameter int SAMPLE_DEPTH = 64
) (
  input  logic                sys_clk,
  input  logic                global_clock_reset,
  input  logic [4:0]          host_addr,
  input  logic [15:0]         host_wdata,
  input  logic                host_wr,
  input  logic                host_rd,
  output logic [15:0]         host_rdata,
  output logic                host_rvalid,
  input  logic [NUM_PINS-1:0] pin_in,
  output logic [NUM_PINS-1:0] pin_out
);

  // command path
  host_bus_pkg::cmd_t staged_cmd;
  host_bus_pkg::cmd_t fifo_head;
  host_bus_pkg::cmd_t cmd_bus;
  logic               push;
  logic               pop;
  logic               fifo_empty;
  logic               fifo_full;
  logic               cmd_bus_valid;
  logic [31:0]        time_now;

  // sample path
  logic [NUM_PINS-1:0]                  sample_req;
  logic [NUM_PINS-1:0]                  sample_grant;
  pin_ctrl_pkg::sample_t [NUM_PINS-1:0] sample_word;
  logic                                 wr_en;
  pin_ctrl_pkg::sample_t                wr_data;
  logic                                 rd_pop;
  pin_ctrl_pkg::sample_t                rd_data;
  logic [15:0]                          count;
  logic                                 sample_dropped;

  host_port u_host_port (
    .sys_clk(sys_clk), .global_clock_reset(global_clock_reset),
    .host_addr(host_addr), .host_wdata(host_wdata),
    .host_wr(host_wr), .host_rd(host_rd),
    .host_rdata(host_rdata), .host_rvalid(host_rvalid),
    .push(push), .cmd(staged_cmd),
    .fifo_full(fifo_full), .fifo_empty(fifo_empty), .time_now(time_now),
    .rd_pop(rd_pop), .rd_data(rd_data), .count(count),
    .sample_dropped(sample_dropped)
  );

  command_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_command_fifo (
    .sys_clk(sys_clk), .global_clock_reset(global_clock_reset),
    .push(push), .din(staged_cmd), .pop(pop),
    .head(fifo_head), .empty(fifo_empty), .full(fifo_full)
  );

  event_scheduler u_event_scheduler (
    .sys_clk(sys_clk), .global_clock_reset(global_clock_reset),
    .head(fifo_head), .empty(fifo_empty), .pop(pop),
    .cmd_bus_valid(cmd_bus_valid), .cmd_bus(cmd_bus), .time_now(time_now)
  );

  // every controller sees the bus and filters on its own index
  for (genvar i = 0; i < NUM_PINS; i++) begin : g_pin
    pin_controller #(.PIN_INDEX(i)) u_pin_controller (
      .sys_clk(sys_clk), .global_clock_reset(global_clock_reset),
      .cmd_bus_valid(cmd_bus_valid), .cmd_bus(cmd_bus), .time_now(time_now),
      .pin_in(pin_in[i]), .pin_out(pin_out[i]),
      .sample_req(sample_req[i]), .sample_word(sample_word[i]),
      .sample_grant(sample_grant[i])
    );
  end

  sample_arbiter #(.NUM_PINS(NUM_PINS)) u_sample_arbiter (
    .sys_clk(sys_clk), .global_clock_reset(global_clock_reset),
    .sample_req(sample_req), .sample_word(sample_word),
    .sample_grant(sample_grant), .wr_en(wr_en), .wr_data(wr_data)
  );

  sample_buffer #(.SAMPLE_DEPTH(SAMPLE_DEPTH)) u_sample_buffer (
    .sys_clk(sys_clk), .global_clock_reset(global_clock_reset),
    .wr_en(wr_en), .wr_data(wr_data), .rd_pop(rd_pop),
    .rd_data(rd_data), .count(count), .sample_dropped(sample_dropped)
  );

endmodule

`default_nettype wire

// File: tb/mecobo_core_tb.sv
// directed, file-driven testbench for mecobo_core with default parameters
// operations come from tb/mecobo_patterns.hex, four hex words per line
// time reads are 16 bits wide, so release checks assume a run under 65536 cycles
// the watchdog limit follows the wait counts and the line count of the pattern file
`timescale 1ns/1ps
`default_nettype none

module mecobo_core_tb;

  localparam int NUM_PINS    = 8;
  localparam int MAX_OPS     = 64;
  // cycles allowed per pattern line on top of its explicit wait
  localparam int LINE_MARGIN = 2500;
  localparam int POLL_LIMIT  = 2000;

  // pattern operation codes
  localparam int PAT_END     = 0;
  localparam int PAT_WRITE   = 1;
  localparam int PAT_READ    = 2;
  localparam int PAT_WAIT    = 3;
  localparam int PAT_PIN_IN  = 4;
  localparam int PAT_MEASURE = 5;
  localparam int PAT_RELEASE = 6;
  localparam int PAT_TSTEP   = 7;
  localparam int PAT_RANGE   = 8;
  localparam int PAT_POP     = 9;
  localparam int PAT_TEST    = 10;
  localparam int PAT_REPEAT  = 11;
  localparam int PAT_CMD     = 12;
  localparam int PAT_PINS    = 13;

  logic                sys_clk;
  logic                global_clock_reset;
  logic [4:0]          host_addr;
  logic [15:0]         host_wdata;
  logic                host_wr;
  logic                host_rd;
  logic [15:0]         host_rdata;
  logic                host_rvalid;
  logic [NUM_PINS-1:0] pin_in;
  logic [NUM_PINS-1:0] pin_out;
  logic [15:0]         pins_wide;

  logic [31:0] pat [0:4*MAX_OPS-1];
  int          errors;
  int          checks;
  int          test_errors;
  int          test_id;
  int          tests_run;
  int          tests_failed;
  int          limit_cycles;
  logic        limit_ready = 1'b0;

  mecobo_core dut (
    .sys_clk(sys_clk), .global_clock_reset(global_clock_reset),
    .host_addr(host_addr), .host_wdata(host_wdata),
    .host_wr(host_wr), .host_rd(host_rd),
    .host_rdata(host_rdata), .host_rvalid(host_rvalid),
    .pin_in(pin_in), .pin_out(pin_out)
  );

  // widened copy so a 4-bit pin number can index it
  assign pins_wide = 16'(pin_out);

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;
  end

  // watchdog, armed once the pattern file is loaded
  initial begin
    wait (limit_ready);
    repeat (limit_cycles) @(posedge sys_clk);
    $display("timeout: run did not finish within %0d cycles", limit_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  function automatic string test_name(input int id);
    case (id)
      1: return "reset state and time";
      2: return "scheduled release";
      3: return "square and pwm timing";
      4: return "sampling through arbitration";
      5: return "time reset";
      6: return "overflow flags";
      default: return "unnamed";
    endcase
  endfunction

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("** Error: %s expected %0h got %0h", name, expected, actual);
      note_error();
    end
  endtask

  task automatic finish_test();
    if (test_id != 0) begin
      tests_run++;
      if (test_errors != 0) begin
        tests_failed++;
      end
      $display("test %0d %s: %s, %0d errors", test_id, test_name(test_id),
               (test_errors == 0) ? "ok" : "failed", test_errors);
    end
    test_errors = 0;
  endtask

  // one-cycle write strobe, starts and ends on a falling edge
  task automatic host_write(input logic [4:0] addr, input logic [15:0] data);
    host_addr  = addr;
    host_wdata = data;
    host_wr    = 1'b1;
    @(negedge sys_clk);
    host_wr    = 1'b0;
  endtask

  // data is back one cycle after the strobe
  task automatic host_read(input logic [4:0] addr, output logic [31:0] data);
    host_addr = addr;
    host_rd   = 1'b1;
    @(negedge sys_clk);
    host_rd   = 1'b0;
    checks++;
    if (host_rvalid !== 1'b1) begin
      $display("no host_rvalid one cycle after a read of address %0d", addr);
      note_error();
    end
    data = 32'(host_rdata);
  endtask

  // exec_time stays as staged by earlier writes
  task automatic run_command(input logic [15:0] pin_op, input logic [15:0] a,
                             input logic [15:0] b);
    host_write(host_bus_pkg::REG_PIN_OP, pin_op);
    host_write(host_bus_pkg::REG_PARAM_A, a);
    host_write(host_bus_pkg::REG_PARAM_B, b);
    host_write(host_bus_pkg::REG_COMMIT, 16'd0);
  endtask

  // sync to a rising edge, then count one high run and one low run
  task automatic measure_pin(input int pin, input int exp_high, input int exp_period);
    int guard;
    int high_run;
    int low_run;
    guard    = 0;
    high_run = 0;
    low_run  = 0;
    while (pins_wide[4'(pin)] === 1'b1 && guard < POLL_LIMIT) begin
      @(negedge sys_clk);
      guard++;
    end
    while (pins_wide[4'(pin)] === 1'b0 && guard < POLL_LIMIT) begin
      @(negedge sys_clk);
      guard++;
    end
    while (pins_wide[4'(pin)] === 1'b1 && guard < POLL_LIMIT) begin
      @(negedge sys_clk);
      high_run++;
      guard++;
    end
    while (pins_wide[4'(pin)] === 1'b0 && guard < POLL_LIMIT) begin
      @(negedge sys_clk);
      low_run++;
      guard++;
    end
    if (guard >= POLL_LIMIT) begin
      $display("pin %0d did not toggle within %0d cycles", pin, POLL_LIMIT);
      note_error();
    end else begin
      check_value($sformatf("pin_out[%0d] high run", pin), 32'(exp_high), 32'(high_run));
      check_value($sformatf("pin_out[%0d] period", pin), 32'(exp_period),
                  32'(high_run + low_run));
    end
  endtask

  // pin keeps its old level up to exec_time itself, new level two cycles after
  task automatic watch_release(input int pin, input int exec, input logic level);
    logic [31:0] t;
    int          est;
    bit          early;
    host_read(host_bus_pkg::REG_TIME_NOW, t);
    // counter has moved on by one since the sampled value
    est   = int'(t) + 1;
    early = 1'b0;
    if (est >= exec || exec - est > POLL_LIMIT) begin
      $display("exec_time %0h is not shortly ahead of time %0h", exec, est);
      note_error();
      return;
    end
    checks++;
    while (est < exec + 2) begin
      if (est <= exec && pins_wide[4'(pin)] !== ~level && !early) begin
        early = 1'b1;
        $display("** Error: pin_out[%0d] expected %0h before release got %0h", pin,
                 ~level, pins_wide[4'(pin)]);
        note_error();
      end
      @(negedge sys_clk);
      est++;
    end
    check_value($sformatf("pin_out[%0d]", pin), 32'(level), 32'(pins_wide[4'(pin)]));
  endtask

  // second read strobe lands exactly n cycles after the first
  task automatic check_time_step(input int n);
    logic [31:0] t0;
    logic [31:0] t1;
    host_read(host_bus_pkg::REG_TIME_NOW, t0);
    repeat (n - 1) @(negedge sys_clk);
    host_read(host_bus_pkg::REG_TIME_NOW, t1);
    check_value("time_now delta", 32'(n), (t1 - t0) & 32'hffff);
  endtask

  task automatic pop_samples(input int n, input logic [15:0] mask);
    logic [31:0]           w;
    pin_ctrl_pkg::sample_t s;
    logic [15:0]           held;
    logic [10:0]           last_stamp [16];
    bit                    seen [16];
    logic [10:0]           step;
    held = 16'(pin_in);
    for (int k = 0; k < 16; k++) begin
      seen[k] = 1'b0;
    end
    for (int i = 0; i < n; i++) begin
      host_read(host_bus_pkg::REG_SAMPLE, w);
      s = pin_ctrl_pkg::sample_t'(w[15:0]);
      checks++;
      if (!mask[s.pin]) begin
        $display("** Error: sample pin expected one of mask %0h got %0h", mask, s.pin);
        note_error();
      end else begin
        check_value($sformatf("sample value of pin %0d", s.pin), 32'(held[s.pin]),
                    32'(s.value));
        if (seen[s.pin]) begin
          // stamps wrap at 2048, a step back shows as a huge step forward
          step = s.stamp - last_stamp[s.pin];
          checks++;
          if (step[10]) begin
            $display("** Error: sample stamp of pin %0d expected >= %0h got %0h", s.pin,
                     last_stamp[s.pin], s.stamp);
            note_error();
          end
        end
        seen[s.pin]       = 1'b1;
        last_stamp[s.pin] = s.stamp;
      end
    end
  endtask

  initial begin
    int          line;
    int          op;
    logic [7:0]  base;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] v;
    bit          done;
    host_addr          = '0;
    host_wdata         = '0;
    host_wr            = 1'b0;
    host_rd            = 1'b0;
    pin_in             = '0;
    global_clock_reset = 1'b1;
    errors             = 0;
    checks             = 0;
    test_errors        = 0;
    test_id            = 0;
    tests_run          = 0;
    tests_failed       = 0;
    $readmemh("tb/mecobo_patterns.hex", pat);
    limit_cycles = 20;
    for (int i = 0; i < MAX_OPS; i++) begin
      base = 8'(4 * i);
      if (pat[base] == 32'h0) begin
        break;
      end
      limit_cycles += LINE_MARGIN;
      if (pat[base] == 32'(PAT_WAIT)) begin
        limit_cycles += int'(pat[base + 8'd2]);
      end
    end
    limit_ready = 1'b1;
    repeat (10) @(negedge sys_clk);
    global_clock_reset = 1'b0;
    @(negedge sys_clk);
    line = 0;
    done = 1'b0;
    while (!done && line < MAX_OPS) begin
      base = 8'(4 * line);
      op   = int'(pat[base]);
      f1   = pat[base + 8'd1];
      f2   = pat[base + 8'd2];
      f3   = pat[base + 8'd3];
      case (op)
        PAT_END:     done = 1'b1;
        PAT_WRITE:   host_write(f1[4:0], f2[15:0]);
        PAT_READ: begin
          host_read(f1[4:0], v);
          check_value($sformatf("host_rdata@%0d", f1), f3, v & f2);
        end
        PAT_WAIT:    repeat (int'(f2)) @(negedge sys_clk);
        PAT_PIN_IN:  pin_in = f2[NUM_PINS-1:0];
        PAT_MEASURE: measure_pin(int'(f1), int'(f2), int'(f3));
        PAT_RELEASE: watch_release(int'(f1), int'(f2), f3[0]);
        PAT_TSTEP:   check_time_step(int'(f2));
        PAT_RANGE: begin
          host_read(f1[4:0], v);
          checks++;
          if (v < f2 || v > f3) begin
            $display("** Error: host_rdata@%0d expected %0h..%0h got %0h", f1, f2, f3, v);
            note_error();
          end
        end
        PAT_POP:     pop_samples(int'(f2), f3[15:0]);
        PAT_TEST: begin
          finish_test();
          test_id = int'(f2);
        end
        PAT_REPEAT: begin
          for (int k = 0; k < int'(f3); k++) begin
            host_write(f1[4:0], f2[15:0]);
          end
        end
        PAT_CMD:     run_command(f1[15:0], f2[15:0], f3[15:0]);
        PAT_PINS:    check_value("pin_out", f3, f2 & 32'(pin_out));
        default: begin
          $display("unknown operation %0h on pattern line %0d", op, line);
          note_error();
        end
      endcase
      line++;
    end
    if (!done) begin
      $display("pattern file has no end operation");
      note_error();
    end
    finish_test();
    $display("tests: %0d run, %0d failed; checks: %0d; errors: %0d", tests_run,
             tests_failed, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/mecobo_patterns.hex
// columns: op addr_or_pin data expect, all hex, one operation per line
// op 1 write, 2 read (data mask), 3 wait, 4 pin_in, 5 measure (high, period), 6 release (exec, level)
// op 7 time step, 8 read in range, 9 pop (pin mask), a test, b repeat write, c command, d pin_out, 0 end
a 0 1 0
3 0 5 0
2 8 ffff 1
d 0 ff 0
7 0 25 0
a 0 2 0
1 0 0 0
1 1 200 0
c 1 0 1
6 1 200 1
a 0 3 0
c 42 6 0
5 2 6 c
c 83 a 3
5 3 3 a
a 0 4 0
4 0 50 0
c 14 5 0
c 15 7 0
c 16 9 0
3 0 64 0
8 a 28 34
9 0 20 70
c 24 0 0
c 25 0 0
c 26 0 0
a 0 5 0
1 1 200 0
c 30 0 0
3 0 4 0
8 b 0 1ff
a 0 6 0
1 1 0 0
c 14 3 0
c 15 3 0
c 16 3 0
3 0 80 0
8 a 40 40
2 8 8 8
1 0 1 0
1 2 7 0
b 5 0 11
2 8 f e
0 0 0 0

// File: mecobo_core.f
logic/pin_ctrl_pkg.sv
logic/host_bus_pkg.sv
logic/host_port.sv
logic/command_fifo.sv
logic/event_scheduler.sv
logic/pin_controller.sv
logic/sample_arbiter.sv
logic/sample_buffer.sv
logic/mecobo_core.sv
tb/mecobo_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the mecobo_core testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --top-module mecobo_core_tb -f mecobo_core.f -o mecobo_sim > "$log" 2>&1 \
  && ./obj_dir/mecobo_sim >> "$log" 2>&1 \
  || { cat "$log"; echo "build or simulation error"; exit 1; }

cat "$log"
grep -q "FAIL: see errors above" "$log" && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
